/* files.f */
+incdir+tests
source/rvviTracePkg.sv
source/retireIf.sv
source/rvfiCapture.sv
source/retireFifo.sv
source/rvviTraceOut.sv
source/rvviTraceTop.sv
tests/rvviTraceTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide the verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module rvviTraceTb -f files.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* source/retireFifo.sv */
// Show-ahead FIFO of retirement records with full, empty and a sticky overflow flag
`timescale 1ns/1ns

module retireFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic    rvvi,
    input  logic    rstN_i,
    retireIf.fifo   retire,
    output logic    overflow_o
);
    import rvviTracePkg::*;

    // Depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    retireRecT        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic             doWrite;
    logic             doRead;

    //////////////////////////////////////////////////
    // Status and head
    //////////////////////////////////////////////////

    assign retire.full   = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign retire.empty  = (count == '0);
    assign retire.popRec = mem[rdPtr];

    // Push into a full buffer is lost
    assign doWrite = retire.push && !retire.full;
    assign doRead  = retire.pop && !retire.empty;

    //////////////////////////////////////////////////
    // Pointers, count and overflow
    //////////////////////////////////////////////////

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
            // Sticky until reset
            if (retire.push && retire.full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge rvvi) begin
        if (doWrite) begin
            mem[wrPtr] <= retire.pushRec;
        end
    end

    // Output stage must look at empty before it pops
    noPopWhileEmpty: assert property (@(posedge rvvi) disable iff (!rstN_i)
        !(retire.pop && retire.empty))
        else $error("Pop issued while the retirement FIFO is empty");

endmodule

/* source/retireIf.sv */
// Retirement record channel linking the capture stage, the FIFO and the trace output stage
`timescale 1ns/1ns

interface retireIf;
    import rvviTracePkg::*;

    // Producer side, one-cycle push strobe
    logic      push;
    retireRecT pushRec;
    // FIFO status
    logic      full;
    logic      empty;
    // Consumer side, show-ahead head record
    logic      pop;
    retireRecT popRec;

    // Capture stage writes records
    modport capture (output push, output pushRec, input full);

    // FIFO sits between the two ends
    modport fifo (input push, input pushRec, input pop,
                  output full, output popRec, output empty);

    // Output stage drains records
    modport drain (output pop, input popRec, input empty);

endinterface

/* source/rvfiCapture.sv */
// Capture stage that registers one retirement per cycle and pushes a resolved record
`timescale 1ns/1ns

module rvfiCapture (
    input  logic                                    rvvi,
    input  logic                                    rstN_i,
    // Retirement strobe and identity
    input  logic                                    retireValid_i,
    input  logic [rvviTracePkg::ORDER_W-1:0]        order_i,
    input  logic [rvviTracePkg::XLEN-1:0]           pc_i,
    input  logic [rvviTracePkg::XLEN-1:0]           insn_i,
    input  logic                                    trap_i,
    input  logic                                    intr_i,
    // Two GPR write ports
    input  logic [rvviTracePkg::REG_ADDR_W-1:0]     rdAddr0_i,
    input  logic [rvviTracePkg::REG_ADDR_W-1:0]     rdAddr1_i,
    input  logic [rvviTracePkg::XLEN-1:0]           rdWdata0_i,
    input  logic [rvviTracePkg::XLEN-1:0]           rdWdata1_i,
    // One CSR access
    input  rvviTracePkg::csrSelE                    csrSel_i,
    input  logic [rvviTracePkg::XLEN-1:0]           csrWdata_i,
    input  logic [rvviTracePkg::XLEN-1:0]           csrRdata_i,
    input  logic [rvviTracePkg::XLEN-1:0]           csrWmask_i,
    retireIf.capture                                retire
);
    import rvviTracePkg::*;

    retireRecT nextRec;

    //////////////////////////////////////////////////
    // Record resolution
    //////////////////////////////////////////////////

    always_comb begin
        nextRec       = '0;
        nextRec.order = order_i;
        nextRec.pc    = pc_i;
        nextRec.insn  = insn_i;
        nextRec.trap  = trap_i;
        nextRec.intr  = intr_i;

        // One mask bit per nonzero destination, equal addresses share a bit
        if (rdAddr0_i != '0) begin
            nextRec.xWbMask[rdAddr0_i] = 1'b1;
        end
        if (rdAddr1_i != '0) begin
            nextRec.xWbMask[rdAddr1_i] = 1'b1;
        end

        // x0 never carries data
        if (rdAddr0_i == '0) begin
            nextRec.rdWdata0 = '0;
        end else if (rdAddr0_i == rdAddr1_i) begin
            // Same register on both ports, port 1 is the later write
            nextRec.rdWdata0 = rdWdata1_i;
        end else begin
            nextRec.rdWdata0 = rdWdata0_i;
        end
        nextRec.rdWdata1 = (rdAddr1_i == '0) ? '0 : rdWdata1_i;

        // Written bits from wdata, untouched bits from rdata
        nextRec.csrSel   = csrSel_i;
        nextRec.csrValue = (csrWdata_i & csrWmask_i) | (csrRdata_i & ~csrWmask_i);
    end

    //////////////////////////////////////////////////
    // Push register
    //////////////////////////////////////////////////

    // Strobe follows retireValid_i by one edge
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            retire.push <= 1'b0;
        end else begin
            retire.push <= retireValid_i;
        end
    end

    // Record held until the next retirement
    always_ff @(posedge rvvi) begin
        if (retireValid_i) begin
            retire.pushRec <= nextRec;
        end
    end

    // Downstream must keep up, otherwise records are dropped in the FIFO
    noPushWhileFull: assert property (@(posedge rvvi) disable iff (!rstN_i)
        !(retire.push && retire.full))
        else $warning("Retirement pushed into a full FIFO");

endmodule

/* source/rvviTraceOut.sv */
// Trace output stage that arbitrates interrupt net events ahead of buffered retirements
`timescale 1ns/1ns

module rvviTraceOut (
    input  logic                                    rvvi,
    input  logic                                    rstN_i,
    input  logic [rvviTracePkg::IRQ_W-1:0]          irq_i,
    retireIf.drain                                  retire,
    // Trace channel
    output logic                                    traceValid_o,
    output rvviTracePkg::traceKindE                 traceKind_o,
    output logic [rvviTracePkg::ORDER_W-1:0]        order_o,
    output logic [rvviTracePkg::XLEN-1:0]           pc_o,
    output logic [rvviTracePkg::XLEN-1:0]           insn_o,
    output logic                                    trap_o,
    output logic                                    intr_o,
    output logic [rvviTracePkg::NUM_REGS-1:0]       xWbMask_o,
    output logic [rvviTracePkg::XLEN-1:0]           rdWdata0_o,
    output logic [rvviTracePkg::XLEN-1:0]           rdWdata1_o,
    output rvviTracePkg::csrSelE                    csrSel_o,
    output logic [rvviTracePkg::XLEN-1:0]           csrValue_o,
    output logic                                    csrChanged_o,
    output logic [rvviTracePkg::REG_ADDR_W-1:0]     netIndex_o,
    output logic                                    netLevel_o
);
    import rvviTracePkg::*;

    // Last reported level of each line
    logic [IRQ_W-1:0]      irqLevel;
    logic [IRQ_W-1:0]      irqDiff;
    logic                  netPending;
    logic [REG_ADDR_W-1:0] netIdx;
    // Shadow per kept CSR, CSR_NONE has no slot
    logic [XLEN-1:0]       csrShadow [CSR_MSTATUS:CSR_MCAUSE];
    logic                  csrNew;
    retireRecT             headRec;

    assign headRec = retire.popRec;

    //////////////////////////////////////////////////
    // Net event detection
    //////////////////////////////////////////////////

    // Unmonitored lines never raise an event
    assign irqDiff    = (irq_i ^ irqLevel) & IRQ_MASK;
    assign netPending = |irqDiff;

    // Lowest changed index wins
    always_comb begin
        netIdx = '0;
        for (int i = IRQ_W - 1; i >= 0; i--) begin
            if (irqDiff[i]) begin
                netIdx = REG_ADDR_W'(i);
            end
        end
    end

    // Retirements wait while any net event is pending
    assign retire.pop = !netPending && !retire.empty;

    // Change flag against the shadow of the selected CSR
    always_comb begin
        csrNew = 1'b0;
        if (headRec.csrSel != CSR_NONE) begin
            csrNew = (headRec.csrValue != csrShadow[headRec.csrSel]);
        end
    end

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            traceValid_o <= 1'b0;
            traceKind_o  <= TRACE_RETIRE;
            irqLevel     <= '0;
            for (int i = int'(CSR_MSTATUS); i <= int'(CSR_MCAUSE); i++) begin
                csrShadow[i] <= '0;
            end
        end else begin
            // At most one item per cycle
            traceValid_o <= netPending || retire.pop;
            if (netPending) begin
                traceKind_o      <= TRACE_NET;
                irqLevel[netIdx] <= irq_i[netIdx];
            end else if (retire.pop) begin
                traceKind_o <= TRACE_RETIRE;
                if (headRec.csrSel != CSR_NONE) begin
                    csrShadow[headRec.csrSel] <= headRec.csrValue;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Trace payload
    //////////////////////////////////////////////////

    always_ff @(posedge rvvi) begin
        if (netPending) begin
            netIndex_o <= netIdx;
            netLevel_o <= irq_i[netIdx];
        end else if (retire.pop) begin
            order_o      <= headRec.order;
            pc_o         <= headRec.pc;
            insn_o       <= headRec.insn;
            trap_o       <= headRec.trap;
            intr_o       <= headRec.intr;
            xWbMask_o    <= headRec.xWbMask;
            rdWdata0_o   <= headRec.rdWdata0;
            rdWdata1_o   <= headRec.rdWdata1;
            csrSel_o     <= headRec.csrSel;
            csrValue_o   <= headRec.csrValue;
            csrChanged_o <= csrNew;
        end
    end

    // Net items only ever name a monitored line
    netIndexMonitored: assert property (@(posedge rvvi) disable iff (!rstN_i)
        (traceValid_o && traceKind_o == TRACE_NET) |-> IRQ_MASK[netIndex_o])
        else $error("Net event reported on unmonitored line %0d", netIndex_o);

endmodule

/* source/rvviTracePkg.sv */
// Shared widths, CSR and trace encodings and the retirement record, imported by every stage
package rvviTracePkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Register and data widths of the traced hart
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    // Retirement order counter
    localparam int ORDER_W    = 64;
    // Core interrupt vector
    localparam int IRQ_W      = 32;

    // Monitored lines: software 3, timer 7, external 11, local 16 to 31
    localparam logic [IRQ_W-1:0] IRQ_MASK = 32'hFFFF_0888;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // CSR reported by one retirement
    typedef enum logic [2:0] {
        CSR_NONE,
        CSR_MSTATUS,
        CSR_MIE,
        CSR_MTVEC,
        CSR_MSCRATCH,
        CSR_MEPC,
        CSR_MCAUSE
    } csrSelE;

    // Kind of item on the trace channel
    typedef enum logic {
        TRACE_RETIRE,
        TRACE_NET
    } traceKindE;

    // One resolved retirement, as stored in the FIFO
    typedef struct packed {
        logic [ORDER_W-1:0]  order;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     insn;
        logic                trap;
        logic                intr;
        // GPR writeback, one bit per register
        logic [NUM_REGS-1:0] xWbMask;
        logic [XLEN-1:0]     rdWdata0;
        logic [XLEN-1:0]     rdWdata1;
        // Merged CSR value
        csrSelE              csrSel;
        logic [XLEN-1:0]     csrValue;
    } retireRecT;

endpackage

/* source/rvviTraceTop.sv */
// Top level of the retirement trace converter, plain ports around capture, FIFO and output
`timescale 1ns/1ns

module rvviTraceTop #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                    rvvi,
    input  logic                                    rstN_i,
    // Retirement side
    input  logic                                    retireValid_i,
    input  logic [rvviTracePkg::ORDER_W-1:0]        order_i,
    input  logic [rvviTracePkg::XLEN-1:0]           pc_i,
    input  logic [rvviTracePkg::XLEN-1:0]           insn_i,
    input  logic                                    trap_i,
    input  logic                                    intr_i,
    input  logic [rvviTracePkg::REG_ADDR_W-1:0]     rdAddr0_i,
    input  logic [rvviTracePkg::REG_ADDR_W-1:0]     rdAddr1_i,
    input  logic [rvviTracePkg::XLEN-1:0]           rdWdata0_i,
    input  logic [rvviTracePkg::XLEN-1:0]           rdWdata1_i,
    input  rvviTracePkg::csrSelE                    csrSel_i,
    input  logic [rvviTracePkg::XLEN-1:0]           csrWdata_i,
    input  logic [rvviTracePkg::XLEN-1:0]           csrRdata_i,
    input  logic [rvviTracePkg::XLEN-1:0]           csrWmask_i,
    input  logic [rvviTracePkg::IRQ_W-1:0]          irq_i,
    // Trace side
    output logic                                    traceValid_o,
    output rvviTracePkg::traceKindE                 traceKind_o,
    output logic [rvviTracePkg::ORDER_W-1:0]        order_o,
    output logic [rvviTracePkg::XLEN-1:0]           pc_o,
    output logic [rvviTracePkg::XLEN-1:0]           insn_o,
    output logic                                    trap_o,
    output logic                                    intr_o,
    output logic [rvviTracePkg::NUM_REGS-1:0]       xWbMask_o,
    output logic [rvviTracePkg::XLEN-1:0]           rdWdata0_o,
    output logic [rvviTracePkg::XLEN-1:0]           rdWdata1_o,
    output rvviTracePkg::csrSelE                    csrSel_o,
    output logic [rvviTracePkg::XLEN-1:0]           csrValue_o,
    output logic                                    csrChanged_o,
    output logic [rvviTracePkg::REG_ADDR_W-1:0]     netIndex_o,
    output logic                                    netLevel_o,
    // Sticky lost-retirement flag
    output logic                                    overflow_o
);

    // Record channel shared by the three stages
    retireIf retireBus ();

    // Producer
    rvfiCapture capture0 (
        .rvvi          (rvvi),
        .rstN_i        (rstN_i),
        .retireValid_i (retireValid_i),
        .order_i       (order_i),
        .pc_i          (pc_i),
        .insn_i        (insn_i),
        .trap_i        (trap_i),
        .intr_i        (intr_i),
        .rdAddr0_i     (rdAddr0_i),
        .rdAddr1_i     (rdAddr1_i),
        .rdWdata0_i    (rdWdata0_i),
        .rdWdata1_i    (rdWdata1_i),
        .csrSel_i      (csrSel_i),
        .csrWdata_i    (csrWdata_i),
        .csrRdata_i    (csrRdata_i),
        .csrWmask_i    (csrWmask_i),
        .retire        (retireBus.capture)
    );

    // Buffer
    retireFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .rvvi       (rvvi),
        .rstN_i     (rstN_i),
        .retire     (retireBus.fifo),
        .overflow_o (overflow_o)
    );

    // Consumer and trace driver
    rvviTraceOut traceOut0 (
        .rvvi         (rvvi),
        .rstN_i       (rstN_i),
        .irq_i        (irq_i),
        .retire       (retireBus.drain),
        .traceValid_o (traceValid_o),
        .traceKind_o  (traceKind_o),
        .order_o      (order_o),
        .pc_o         (pc_o),
        .insn_o       (insn_o),
        .trap_o       (trap_o),
        .intr_o       (intr_o),
        .xWbMask_o    (xWbMask_o),
        .rdWdata0_o   (rdWdata0_o),
        .rdWdata1_o   (rdWdata1_o),
        .csrSel_o     (csrSel_o),
        .csrValue_o   (csrValue_o),
        .csrChanged_o (csrChanged_o),
        .netIndex_o   (netIndex_o),
        .netLevel_o   (netLevel_o)
    );

endmodule

/* tests/tbVectors.svh */
// Stimulus table for the trace converter testbench, included inside the testbench module
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: flags {retire, trap, intr}, rd0, rd1, csr, wdata, rdata, wmask, irq, idle cycles
typedef struct packed {
    logic [2:0]  flags;
    logic [4:0]  rd0;
    logic [4:0]  rd1;
    csrSelE      csr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] wmask;
    logic [31:0] irq;
    logic [7:0]  idle;
} vecRowT;

localparam int NUM_ROWS = 26;

localparam vecRowT VECTORS [NUM_ROWS] = '{
    // Plain ordering, trap and intr flags, GPR port cases
    '{3'b100, 5'd1, 5'd2, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 8'd3},
    '{3'b110, 5'd4, 5'd0, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 8'd2},
    '{3'b101, 5'd0, 5'd6, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 8'd4},
    '{3'b100, 5'd5, 5'd9, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 8'd1},
    '{3'b100, 5'd7, 5'd7, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 8'd1},
    '{3'b100, 5'd0, 5'd0, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 8'd2},
    // CSR merge, first write, repeat, partial mask, no CSR, unchanged zero
    '{3'b100, 5'd10, 5'd0, CSR_MSCRATCH, 32'h12345678, 32'h0, 32'hFFFFFFFF, 32'h0, 8'd2},
    '{3'b100, 5'd11, 5'd0, CSR_MSCRATCH, 32'h12345678, 32'h0, 32'hFFFFFFFF, 32'h0, 8'd2},
    '{3'b100, 5'd12, 5'd0, CSR_MSTATUS, 32'hA5A5A5A5, 32'h0F0F0F0F, 32'h0000FFFF, 32'h0, 8'd2},
    '{3'b100, 5'd0, 5'd13, CSR_MSTATUS, 32'h0, 32'h0F0FA5A5, 32'h0, 32'h0, 8'd2},
    '{3'b100, 5'd14, 5'd0, CSR_NONE, 32'hDEADBEEF, 32'h0, 32'hFFFF0000, 32'h0, 8'd2},
    '{3'b100, 5'd0, 5'd0, CSR_MTVEC, 32'h0, 32'h0, 32'h0000FFFF, 32'h0, 8'd2},
    // Net events only, line 5 is not monitored
    '{3'b000, 5'd0, 5'd0, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h000108A8, 8'd8},
    '{3'b000, 5'd0, 5'd0, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h00010008, 8'd6},
    // Five events ahead of four retirements
    '{3'b100, 5'd15, 5'd16, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'hC0010880, 8'd0},
    '{3'b100, 5'd17, 5'd0, CSR_MEPC, 32'h80000100, 32'h0, 32'hFFFFFFFF, 32'hC0010880, 8'd0},
    '{3'b100, 5'd18, 5'd0, CSR_MCAUSE, 32'h8000000B, 32'h0, 32'hFFFFFFFF, 32'hC0010880, 8'd0},
    '{3'b110, 5'd19, 5'd19, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'hC0010880, 8'd10},
    // Storm on all monitored lines with an eight deep burst
    '{3'b100, 5'd20, 5'd0, CSR_MIE, 32'h00000888, 32'h0, 32'hFFFFFFFF, 32'h3FFE0008, 8'd0},
    '{3'b100, 5'd21, 5'd0, CSR_MIE, 32'h00000888, 32'h0, 32'hFFFFFFFF, 32'h3FFE0008, 8'd0},
    '{3'b110, 5'd22, 5'd23, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h3FFE0008, 8'd0},
    '{3'b100, 5'd24, 5'd0, CSR_MSCRATCH, 32'h12345678, 32'h0, 32'hFFFFFFFF, 32'h3FFE0008, 8'd0},
    '{3'b100, 5'd25, 5'd0, CSR_MIE, 32'h0000FFFF, 32'h0, 32'hFFFFFFFF, 32'h3FFE0008, 8'd0},
    '{3'b101, 5'd26, 5'd0, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h3FFE0008, 8'd0},
    '{3'b100, 5'd27, 5'd28, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h3FFE0008, 8'd0},
    '{3'b100, 5'd29, 5'd0, CSR_NONE, 32'h0, 32'h0, 32'h0, 32'h3FFE0008, 8'd30}
};

`endif

/* tests/rvviTraceTb.sv */
// Testbench for the trace converter, applies the stimulus table and checks every trace item
`timescale 1ns/1ns

module rvviTraceTb;
    import rvviTracePkg::*;

    `include "tbVectors.svh"

    localparam int FIFO_DEPTH   = 4;
    // Reset, per-row budget and drain margin
    localparam int LIMIT_CYCLES = 16 + NUM_ROWS * 20 + 200;

    // Expected retirement item
    typedef struct packed {
        logic [ORDER_W-1:0]  order;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     insn;
        logic                trap;
        logic                intr;
        logic [NUM_REGS-1:0] mask;
        logic [XLEN-1:0]     data0;
        logic [XLEN-1:0]     data1;
        csrSelE              csr;
        logic [XLEN-1:0]     value;
        logic                changed;
    } expRetT;

    // Expected net event
    typedef struct packed {
        logic [REG_ADDR_W-1:0] idx;
        logic                  level;
        // Time the line change was driven
        logic [63:0]           queuedAt;
    } expNetT;

    logic rvvi = 1'b0;
    logic rstN_i;
    logic retireValid_i;
    logic trap_i;
    logic intr_i;
    logic [ORDER_W-1:0] order_i;
    logic [XLEN-1:0] pc_i, insn_i, rdWdata0_i, rdWdata1_i, csrWdata_i, csrRdata_i, csrWmask_i;
    logic [REG_ADDR_W-1:0] rdAddr0_i, rdAddr1_i;
    csrSelE csrSel_i;
    logic [IRQ_W-1:0] irq_i;
    logic traceValid_o, trap_o, intr_o, csrChanged_o, netLevel_o, overflow_o;
    traceKindE traceKind_o;
    logic [ORDER_W-1:0] order_o;
    logic [XLEN-1:0] pc_o, insn_o, rdWdata0_o, rdWdata1_o, csrValue_o;
    logic [NUM_REGS-1:0] xWbMask_o;
    csrSelE csrSel_o;
    logic [REG_ADDR_W-1:0] netIndex_o;

    // Reference model state
    expRetT retQ [$];
    expNetT netQ [$];
    expRetT retHead;
    expNetT netHead;
    logic [XLEN-1:0] shadowRef [8];
    logic [IRQ_W-1:0] reportedIrq;
    logic [ORDER_W-1:0] orderCnt;
    logic expOverflow;
    // Stall tracking after the latest interrupt change
    int stallCycles;
    int rowOffset;
    int stalledCount;

    rvviTraceTop #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

    always #10 rvvi = ~rvvi;

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic stopOnFailure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
            stopOnFailure();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////

    task automatic applyRow(input vecRowT row);
        logic [IRQ_W-1:0] diff;
        expRetT er;
        expNetT en;
        logic [XLEN-1:0] w0;
        logic [XLEN-1:0] w1;
        er = '0;
        er.order = orderCnt;
        er.pc    = $urandom();
        er.insn  = $urandom();
        er.trap  = row.flags[1];
        er.intr  = row.flags[0];
        w0 = $urandom();
        w1 = $urandom();
        // Each moved monitored line is one event, ascending
        diff = (row.irq ^ reportedIrq) & IRQ_MASK;
        if (diff != '0) begin
            stallCycles  = $countones(diff);
            rowOffset    = 0;
            stalledCount = 0;
            for (int b = 0; b < IRQ_W; b++) begin
                if (diff[b]) begin
                    en.idx      = REG_ADDR_W'(b);
                    en.level    = row.irq[b];
                    en.queuedAt = $time;
                    netQ.push_back(en);
                end
            end
        end
        reportedIrq = row.irq;
        // Nonzero destinations set a bit, port 1 wins on equal addresses
        if (row.rd0 != '0) er.mask[row.rd0] = 1'b1;
        if (row.rd1 != '0) er.mask[row.rd1] = 1'b1;
        er.data0 = (row.rd0 == '0) ? '0 : ((row.rd0 == row.rd1) ? w1 : w0);
        er.data1 = (row.rd1 == '0) ? '0 : w1;
        er.csr   = row.csr;
        // Each bit from wdata where the mask is set, from rdata elsewhere
        for (int b = 0; b < XLEN; b++) begin
            er.value[b] = row.wmask[b] ? row.wdata[b] : row.rdata[b];
        end
        retireValid_i <= row.flags[2];
        order_i       <= er.order;
        pc_i          <= er.pc;
        insn_i        <= er.insn;
        trap_i        <= er.trap;
        intr_i        <= er.intr;
        rdAddr0_i     <= row.rd0;
        rdAddr1_i     <= row.rd1;
        rdWdata0_i    <= w0;
        rdWdata1_i    <= w1;
        csrSel_i      <= row.csr;
        csrWdata_i    <= row.wdata;
        csrRdata_i    <= row.rdata;
        csrWmask_i    <= row.wmask;
        irq_i         <= row.irq;
        if (row.flags[2]) begin
            // Only FIFO_DEPTH retirements survive a net event stall
            if (rowOffset < stallCycles && stalledCount >= FIFO_DEPTH) begin
                expOverflow = 1'b1;
            end else begin
                if (rowOffset < stallCycles) stalledCount++;
                if (row.csr != CSR_NONE) begin
                    er.changed = (er.value != shadowRef[int'(row.csr)]);
                    shadowRef[int'(row.csr)] = er.value;
                end
                retQ.push_back(er);
            end
            orderCnt++;
        end
        rowOffset += 1 + int'(row.idle);
    endtask

    initial begin
        rstN_i        <= 1'b0;
        retireValid_i <= 1'b0;
        order_i       <= '0;
        pc_i          <= '0;
        insn_i        <= '0;
        trap_i        <= 1'b0;
        intr_i        <= 1'b0;
        rdAddr0_i     <= '0;
        rdAddr1_i     <= '0;
        rdWdata0_i    <= '0;
        rdWdata1_i    <= '0;
        csrSel_i      <= CSR_NONE;
        csrWdata_i    <= '0;
        csrRdata_i    <= '0;
        csrWmask_i    <= '0;
        irq_i         <= '0;
        reportedIrq  = '0;
        orderCnt     = 64'hF000_0000_0000_0010;
        expOverflow  = 1'b0;
        stallCycles  = 0;
        rowOffset    = 0;
        stalledCount = 0;
        foreach (shadowRef[i]) shadowRef[i] = '0;
        void'($urandom(16));
        repeat (16) @(posedge rvvi);
        rstN_i <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge rvvi);
            applyRow(VECTORS[i]);
            repeat (int'(VECTORS[i].idle)) begin
                @(posedge rvvi);
                retireValid_i <= 1'b0;
            end
        end
        @(posedge rvvi);
        retireValid_i <= 1'b0;
        // Drain, then a few quiet cycles to catch stray items
        while (retQ.size() != 0 || netQ.size() != 0) @(negedge rvvi);
        repeat (10) @(negedge rvvi);
        checkValue("overflow_o", 64'(overflow_o), 64'(expOverflow));
        $display("TESTBENCH PASSED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Monitor and watchdog
    //////////////////////////////////////////////////

    // Outputs are registered, so sample mid-cycle
    always @(negedge rvvi) begin
        if (rstN_i && traceValid_o) begin
            if (traceKind_o == TRACE_NET) begin
                if (netQ.size() == 0) begin
                    $display("Unexpected net event on line %0d", netIndex_o);
                    stopOnFailure();
                end else begin
                    netHead = netQ.pop_front();
                    checkValue("netIndex_o", 64'(netIndex_o), 64'(netHead.idx));
                    checkValue("netLevel_o", 64'(netLevel_o), 64'(netHead.level));
                end
            end else if (retQ.size() == 0) begin
                $display("Unexpected retirement with order %h", order_o);
                stopOnFailure();
            end else begin
                // A line change seen before the last edge must be traced first
                if (netQ.size() != 0 && netQ[0].queuedAt + 64'd10 < $time) begin
                    $display("Retirement traced while a net event was still pending");
                    stopOnFailure();
                end
                retHead = retQ.pop_front();
                checkValue("order_o", order_o, retHead.order);
                checkValue("pc_o", 64'(pc_o), 64'(retHead.pc));
                checkValue("insn_o", 64'(insn_o), 64'(retHead.insn));
                checkValue("trap_o", 64'(trap_o), 64'(retHead.trap));
                checkValue("intr_o", 64'(intr_o), 64'(retHead.intr));
                checkValue("xWbMask_o", 64'(xWbMask_o), 64'(retHead.mask));
                checkValue("rdWdata0_o", 64'(rdWdata0_o), 64'(retHead.data0));
                checkValue("rdWdata1_o", 64'(rdWdata1_o), 64'(retHead.data1));
                checkValue("csrSel_o", 64'(csrSel_o), 64'(retHead.csr));
                checkValue("csrValue_o", 64'(csrValue_o), 64'(retHead.value));
                checkValue("csrChanged_o", 64'(csrChanged_o), 64'(retHead.changed));
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge rvvi);
        $display("Timeout: the trace stalled before all expected items arrived");
        stopOnFailure();
    end

endmodule
